// File: compile.f
+incdir+source
source/mrdma_ig_pkg.sv
source/mrdma_ig_ctrl.sv
source/mrdma_ig_size.sv
source/mrdma_ig_addr.sv
source/mrdma_ig_stall_cnt.sv
source/mrdma_ig.sv
tests/mrdma_ig_chk.sv
tests/mrdma_ig_monitor.sv
tests/mrdma_ig_tb.sv

// File: Bender.yml
package:
  name: mrdma_ig

sources:
  - include_dirs:
      - source
    files:
      - source/mrdma_ig_pkg.sv
      - source/mrdma_ig_ctrl.sv
      - source/mrdma_ig_size.sv
      - source/mrdma_ig_addr.sv
      - source/mrdma_ig_stall_cnt.sv
      - source/mrdma_ig.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/mrdma_ig_chk.sv
      - tests/mrdma_ig_monitor.sv
      - tests/mrdma_ig_tb.sv

// File: tests/mrdma_ig_tb.sv
// ==================================================
// testbench: seeded random cubes and pack loads with
// random readies on both channels, bounded by a timeout
// ==================================================
`include "mrdma_ig_macros.svh"

module mrdma_ig_tb;
  import mrdma_ig_pkg::*;

  localparam int NUM_TESTS = 9;
  localparam int MAX_H     = 7;
  localparam int MAX_CH    = 127;

  logic                        nvdla_core_clk;
  logic                        nvdla_core_rstn;
  logic                        op_load;
  dim_t                        reg2dp_channel;
  dim_t                        reg2dp_height;
  dim_t                        reg2dp_width;
  precision_e                  reg2dp_in_precision;
  logic [31:0]                 reg2dp_src_base_addr_high;
  logic [26:0]                 reg2dp_src_base_addr_low;
  stride_t                     reg2dp_src_line_stride;
  stride_t                     reg2dp_src_surface_stride;
  logic                        reg2dp_perf_dma_en;
  logic                        dma_rd_req_vld;
  logic                        dma_rd_req_rdy;
  logic [`MRDMA_DMA_PD_W-1:0]  dma_rd_req_pd;
  logic                        ig2cq_pvld;
  logic                        ig2cq_prdy;
  logic [`MRDMA_CQ_PD_W-1:0]   ig2cq_pd;
  logic [`MRDMA_STALL_W-1:0]   dp2reg_mrdma_stall;
  int                          test_count;
  int                          req_count;
  int                          error_count;

  // per-test configuration, drawn before reset
  precision_e   cfg_prec [NUM_TESTS];
  dim_t         cfg_ch [NUM_TESTS];
  dim_t         cfg_w [NUM_TESTS];
  dim_t         cfg_h [NUM_TESTS];
  logic [31:0]  cfg_hi [NUM_TESTS];
  logic [26:0]  cfg_lo [NUM_TESTS];
  stride_t      cfg_line [NUM_TESTS];
  stride_t      cfg_surf [NUM_TESTS];
  logic         cfg_perf [NUM_TESTS];
  int           total_reqs;
  int           assert_fails;
  int           cycles = 0;
  int           limit = 32'h7fff_ffff;

  mrdma_ig u_dut (.*);
  mrdma_ig_monitor u_mon (.*);
  bind mrdma_ig_ctrl mrdma_ig_chk u_chk (.*);

  always #20 nvdla_core_clk = ~nvdla_core_clk;

  always @(posedge nvdla_core_clk) begin
    cycles <= cycles + 1;
  end

  function automatic int cube_requests(input precision_e prec, input dim_t ch,
                                       input dim_t w, input dim_t h);
    int groups;
    groups = (prec == PREC_INT8) ? (ch >> 5) : (ch >> 4);
    if (w == 0 && h == 0) begin
      return 1;
    end else begin
      return (h + 1) * (groups + 1);
    end
  endfunction

  task automatic load_and_walk(input int i);
    @(posedge nvdla_core_clk);
    reg2dp_in_precision       <= cfg_prec[i];
    reg2dp_channel            <= cfg_ch[i];
    reg2dp_width              <= cfg_w[i];
    reg2dp_height             <= cfg_h[i];
    reg2dp_src_base_addr_high <= cfg_hi[i];
    reg2dp_src_base_addr_low  <= cfg_lo[i];
    reg2dp_src_line_stride    <= cfg_line[i];
    reg2dp_src_surface_stride <= cfg_surf[i];
    reg2dp_perf_dma_en        <= cfg_perf[i];
    op_load                   <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    // the accepted request flagged cube end closes the command
    do begin
      @(posedge nvdla_core_clk);
    end while (!(dma_rd_req_vld && dma_rd_req_rdy && ig2cq_pd[`MRDMA_CQ_PD_W-1]));
    repeat (3) @(posedge nvdla_core_clk);
  endtask

  initial begin
    void'($urandom(32'h4085647e));
    nvdla_core_clk            = 1'b0;
    nvdla_core_rstn           = 1'b0;
    op_load                   = 1'b0;
    reg2dp_channel            = '0;
    reg2dp_height             = '0;
    reg2dp_width              = '0;
    reg2dp_in_precision       = PREC_INT8;
    reg2dp_src_base_addr_high = '0;
    reg2dp_src_base_addr_low  = '0;
    reg2dp_src_line_stride    = '0;
    reg2dp_src_surface_stride = '0;
    reg2dp_perf_dma_en        = 1'b0;
    dma_rd_req_rdy            = 1'b0;
    ig2cq_prdy                = 1'b0;
    total_reqs                = 0;
    // first six are full cubes, last three are 1x1 pack loads
    for (int i = 0; i < NUM_TESTS; i++) begin
      cfg_prec[i] = precision_e'(i % 3);
      cfg_ch[i]   = (i < 6) ? dim_t'($urandom_range(MAX_CH)) : dim_t'($urandom);
      cfg_w[i]    = (i < 6) ? dim_t'($urandom_range(255)) : '0;
      cfg_h[i]    = (i < 6) ? dim_t'($urandom_range(MAX_H)) : '0;
      cfg_hi[i]   = $urandom;
      cfg_lo[i]   = 27'($urandom);
      cfg_line[i] = stride_t'($urandom);
      cfg_surf[i] = stride_t'($urandom);
      cfg_perf[i] = (i % 2 == 0);
      total_reqs += cube_requests(cfg_prec[i], cfg_ch[i], cfg_w[i], cfg_h[i]);
    end
    limit = total_reqs * 16 + 200;
    // random readies, each side ready three cycles in four
    fork
      forever begin
        @(posedge nvdla_core_clk);
        dma_rd_req_rdy <= ($urandom_range(3) != 0);
        ig2cq_prdy     <= ($urandom_range(3) != 0);
      end
    join_none
    repeat (3) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      load_and_walk(i);
    end
    assert_fails = u_dut.u_ctrl.u_chk.assert_fails;
    $display("tests %0d of %0d, requests %0d, errors %0d, assertion failures %0d",
             test_count, NUM_TESTS, req_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0 && test_count == NUM_TESTS) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // run ends here if a command never reaches its cube end
  initial begin
    wait (cycles >= limit);
    $display("timeout after %0d cycles, a command never finished", cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// File: tests/mrdma_ig_monitor.sv
// ==================================================
// reference model of the cube walk; scores requests,
// context entries, valids and the stall count
// ==================================================
`include "mrdma_ig_macros.svh"

module mrdma_ig_monitor (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          op_load,
  input  mrdma_ig_pkg::dim_t            reg2dp_channel,
  input  mrdma_ig_pkg::dim_t            reg2dp_height,
  input  mrdma_ig_pkg::dim_t            reg2dp_width,
  input  mrdma_ig_pkg::precision_e      reg2dp_in_precision,
  input  logic [31:0]                   reg2dp_src_base_addr_high,
  input  logic [26:0]                   reg2dp_src_base_addr_low,
  input  mrdma_ig_pkg::stride_t         reg2dp_src_line_stride,
  input  mrdma_ig_pkg::stride_t         reg2dp_src_surface_stride,
  input  logic                          reg2dp_perf_dma_en,
  input  logic                          dma_rd_req_vld,
  input  logic                          dma_rd_req_rdy,
  input  logic [`MRDMA_DMA_PD_W-1:0]    dma_rd_req_pd,
  input  logic                          ig2cq_pvld,
  input  logic                          ig2cq_prdy,
  input  logic [`MRDMA_CQ_PD_W-1:0]     ig2cq_pd,
  input  logic [`MRDMA_STALL_W-1:0]     dp2reg_mrdma_stall,
  output int                            test_count,
  output int                            req_count,
  output int                            error_count
);
  import mrdma_ig_pkg::*;

  logic        active;
  logic        pack;
  logic        stall_en;
  logic        last;
  logic [63:0] base_byte;
  logic [63:0] exp_addr;
  stride_t     line_stride;
  stride_t     surf_stride;
  int          groups;
  int          width;
  int          height;
  int          c_idx;
  int          h_idx;
  int          exp_size;
  int          stall_exp;
  int          test_reqs;
  int          test_errs;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      error_count++;
      test_errs++;
      $display("Error at %0t: %s got %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // one accepted request against the model, then one walk step
  task automatic score_request();
    last     = pack || (c_idx == groups && h_idx == height);
    exp_size = pack ? groups : width;
    exp_addr = base_byte + ((64'(c_idx) * surf_stride + 64'(h_idx) * line_stride) << 5);
    compare("dma_rd_req_pd addr", dma_rd_req_pd[63:0], exp_addr);
    compare("dma_rd_req_pd size", dma_rd_req_pd[78:64], exp_size);
    compare("ig2cq_pd size", ig2cq_pd[12:0], exp_size % 8192);
    compare("ig2cq_pd cube_end", ig2cq_pd[13], last);
    test_reqs++;
    req_count++;
    if (last) begin
      // no stall in the final cycle, so the count is complete here
      compare("dp2reg_mrdma_stall", dp2reg_mrdma_stall, stall_exp);
      test_count++;
      active = 1'b0;
      $display("test %0d %s: %0d requests, %0d stall cycles, %0d errors",
               test_count, pack ? "pack" : "cube", test_reqs, stall_exp, test_errs);
    end else if (h_idx == height) begin
      h_idx = 0;
      c_idx++;
    end else begin
      h_idx++;
    end
  endtask

  always @(posedge nvdla_core_clk) begin
    if (!nvdla_core_rstn) begin
      active      = 1'b0;
      test_count  = 0;
      req_count   = 0;
      error_count = 0;
    end else if (op_load) begin
      // minus-one group count, 32 channels per group for int8, else 16
      groups      = (reg2dp_in_precision == PREC_INT8) ? (reg2dp_channel >> 5)
                                                       : (reg2dp_channel >> 4);
      width       = reg2dp_width;
      height      = reg2dp_height;
      pack        = (width == 0) && (height == 0);
      base_byte   = {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low, 5'b0};
      line_stride = reg2dp_src_line_stride;
      surf_stride = reg2dp_src_surface_stride;
      stall_en    = reg2dp_perf_dma_en;
      active      = 1'b1;
      c_idx       = 0;
      h_idx       = 0;
      stall_exp   = 0;
      test_reqs   = 0;
      test_errs   = 0;
    end else begin
      // each valid follows the other side's ready
      compare("dma_rd_req_vld", dma_rd_req_vld, active && ig2cq_prdy);
      compare("ig2cq_pvld", ig2cq_pvld, active && dma_rd_req_rdy);
      if (active && ig2cq_prdy && dma_rd_req_rdy) begin
        score_request();
      end else if (active && ig2cq_prdy && stall_en) begin
        stall_exp++;
      end
    end
  end

endmodule

// File: tests/mrdma_ig_chk.sv
// ==================================================
// handshake and walk assertions, bound into the ctrl
// ==================================================
module mrdma_ig_chk (
  input logic                   nvdla_core_clk,
  input logic                   nvdla_core_rstn,
  input logic                   op_load,
  input logic                   cmd_process,
  input logic                   cmd_accept,
  input logic                   cube_end,
  input logic                   dma_rd_req_vld,
  input logic                   dma_rd_req_rdy,
  input logic                   ig2cq_pvld,
  input logic                   ig2cq_prdy,
  input mrdma_ig_pkg::cgroup_t  count_c,
  input mrdma_ig_pkg::dim_t     count_h
);
  int assert_fails = 0;

  // cube end only inside an active command
  idle_no_cube_end: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !cmd_process |-> !cube_end)
  else begin
    $error("cube end flagged while the command is idle");
    assert_fails++;
  end

  // dma and context queue take the request in the same cycle
  joint_accept: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_rd_req_vld && dma_rd_req_rdy) == (ig2cq_pvld && ig2cq_prdy))
  else begin
    $error("dma and context queue acceptance differ");
    assert_fails++;
  end

  // walk state and the cube end flag of the payload hold under back-pressure
  hold_when_stalled: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cmd_process && !cmd_accept && !op_load |=>
      $stable(count_c) && $stable(count_h) && $stable(cube_end))
  else begin
    $error("walk state moved without an acceptance");
    assert_fails++;
  end

endmodule

// File: source/mrdma_ig.sv
// ==================================================
// mrdma ingress: walks the cube after a load and issues
// dma read requests with matching context entries
// ==================================================
`include "mrdma_ig_macros.svh"

module mrdma_ig (
  input  logic                                       nvdla_core_clk,
  input  logic                                       nvdla_core_rstn,
  input  logic                                       op_load,
  input  mrdma_ig_pkg::dim_t                         reg2dp_channel,
  input  mrdma_ig_pkg::dim_t                         reg2dp_height,
  input  mrdma_ig_pkg::dim_t                         reg2dp_width,
  input  mrdma_ig_pkg::precision_e                   reg2dp_in_precision,
  input  logic [31:0]                                reg2dp_src_base_addr_high,
  input  logic [32-`MRDMA_ATOM_SHIFT-1:0]            reg2dp_src_base_addr_low,
  input  mrdma_ig_pkg::stride_t                      reg2dp_src_line_stride,
  input  mrdma_ig_pkg::stride_t                      reg2dp_src_surface_stride,
  input  logic                                       reg2dp_perf_dma_en,
  output logic                                       dma_rd_req_vld,
  input  logic                                       dma_rd_req_rdy,
  output logic [`MRDMA_DMA_PD_W-1:0]                 dma_rd_req_pd,
  output logic                                       ig2cq_pvld,
  input  logic                                       ig2cq_prdy,
  output logic [`MRDMA_CQ_PD_W-1:0]                  ig2cq_pd,
  output logic [`MRDMA_STALL_W-1:0]                  dp2reg_mrdma_stall
);
  import mrdma_ig_pkg::*;

  atom_addr_t                base_addr;
  atom_addr_t                req_addr;
  logic [`MRDMA_ADDR_W-1:0]  dma_req_addr;
  cgroup_t                   surf_groups;
  req_size_t                 req_size;
  logic                      pack_mode;
  logic                      cmd_accept;
  logic                      line_end;
  logic                      surf_end;
  logic                      cube_end;

  // high word above the 27-bit atom-aligned low word
  assign base_addr = {reg2dp_src_base_addr_high, reg2dp_src_base_addr_low};

  // ==================================================
  // control and datapath
  // ==================================================
  mrdma_ig_ctrl u_ctrl (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .ig2cq_prdy      (ig2cq_prdy),
    .surf_groups     (surf_groups),
    .pack_mode       (pack_mode),
    .height          (reg2dp_height),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .ig2cq_pvld      (ig2cq_pvld),
    .cmd_accept      (cmd_accept),
    .line_end        (line_end),
    .surf_end        (surf_end),
    .cube_end        (cube_end)
  );

  mrdma_ig_size u_size (
    .reg2dp_channel      (reg2dp_channel),
    .reg2dp_width        (reg2dp_width),
    .reg2dp_height       (reg2dp_height),
    .reg2dp_in_precision (reg2dp_in_precision),
    .surf_groups         (surf_groups),
    .pack_mode           (pack_mode),
    .req_size            (req_size)
  );

  mrdma_ig_addr u_addr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .line_end        (line_end),
    .surf_end        (surf_end),
    .base_addr       (base_addr),
    .line_stride     (reg2dp_src_line_stride),
    .surf_stride     (reg2dp_src_surface_stride),
    .req_addr        (req_addr)
  );

  mrdma_ig_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .perf_en         (reg2dp_perf_dma_en),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .stall_count     (dp2reg_mrdma_stall)
  );

  // ==================================================
  // payloads
  // ==================================================
  // atoms to bytes
  assign dma_req_addr  = {req_addr, {`MRDMA_ATOM_SHIFT{1'b0}}};
  assign dma_rd_req_pd = {req_size, dma_req_addr};
  // context queue keeps only the low size bits
  assign ig2cq_pd      = {cube_end, req_size[`MRDMA_CQ_PD_W-2:0]};

endmodule

// File: source/mrdma_ig_stall_cnt.sv
// ==================================================
// perf counter of dma request cycles stalled by the
// read channel; enable sampled at each load
// ==================================================
`include "mrdma_ig_macros.svh"

module mrdma_ig_stall_cnt (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       op_load,
  input  logic                       perf_en,
  input  logic                       dma_rd_req_vld,
  input  logic                       dma_rd_req_rdy,
  output logic [`MRDMA_STALL_W-1:0]  stall_count
);
  logic cnt_en;

  // enable held for the whole command
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= perf_en;
    end
  end

  // count restarts at every load
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_count <= '0;
    end else if (op_load) begin
      stall_count <= '0;
    end else if (cnt_en && dma_rd_req_vld && !dma_rd_req_rdy) begin
      stall_count <= stall_count + 1'b1;
    end
  end

endmodule

// File: source/mrdma_ig_addr.sv
// ==================================================
// surface and line base address registers; the line
// register is the atom address of the current request
// ==================================================
module mrdma_ig_addr (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  logic                      cmd_accept,
  input  logic                      line_end,
  input  logic                      surf_end,
  input  mrdma_ig_pkg::atom_addr_t  base_addr,
  input  mrdma_ig_pkg::stride_t     line_stride,
  input  mrdma_ig_pkg::stride_t     surf_stride,
  output mrdma_ig_pkg::atom_addr_t  req_addr
);
  import mrdma_ig_pkg::*;

  atom_addr_t base_addr_surf;
  atom_addr_t base_addr_line;
  atom_addr_t next_surf;

  // start of the next channel group
  assign next_surf = base_addr_surf + atom_addr_t'(surf_stride);

  // ==================================================
  // surface base
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_surf <= '0;
    end else if (op_load) begin
      base_addr_surf <= base_addr;
    end else if (cmd_accept && surf_end) begin
      base_addr_surf <= next_surf;
    end
  end

  // ==================================================
  // line base
  // ==================================================
  // jumps to the new surface at group end, else one line down
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
    end else if (op_load) begin
      base_addr_line <= base_addr;
    end else if (cmd_accept) begin
      if (surf_end) begin
        base_addr_line <= next_surf;
      end else if (line_end) begin
        base_addr_line <= base_addr_line + atom_addr_t'(line_stride);
      end
    end
  end

  assign req_addr = base_addr_line;

endmodule

// File: source/mrdma_ig_size.sv
// ==================================================
// channel group count, 1x1 pack detection and the
// size of each read request, all combinational
// ==================================================
`include "mrdma_ig_macros.svh"

module mrdma_ig_size (
  input  mrdma_ig_pkg::dim_t         reg2dp_channel,
  input  mrdma_ig_pkg::dim_t         reg2dp_width,
  input  mrdma_ig_pkg::dim_t         reg2dp_height,
  input  mrdma_ig_pkg::precision_e   reg2dp_in_precision,
  output mrdma_ig_pkg::cgroup_t      surf_groups,
  output logic                       pack_mode,
  output mrdma_ig_pkg::req_size_t    req_size
);
  import mrdma_ig_pkg::*;

  // 32 channels per group for int8, 16 for int16 / fp16
  always_comb begin
    if (reg2dp_in_precision == PREC_INT8) begin
      surf_groups = {1'b0, reg2dp_channel[`MRDMA_DIM_W-1:`MRDMA_ATOM_SHIFT]};
    end else begin
      surf_groups = reg2dp_channel[`MRDMA_DIM_W-1:`MRDMA_ATOM_SHIFT-1];
    end
  end

  // 1x1 cube, single request covering all groups
  assign pack_mode = (reg2dp_width == '0) && (reg2dp_height == '0);

  // pack mode: size by group count
  // otherwise one line of width atoms
  always_comb begin
    if (pack_mode) begin
      req_size = req_size_t'(surf_groups);
    end else begin
      req_size = req_size_t'(reg2dp_width);
    end
  end

endmodule

// File: source/mrdma_ig_ctrl.sv
// ==================================================
// command state, joint dma / context handshake and
// the channel-group and line counters of the walk
// ==================================================
module mrdma_ig_ctrl (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   op_load,
  input  logic                   dma_rd_req_rdy,
  input  logic                   ig2cq_prdy,
  input  mrdma_ig_pkg::cgroup_t  surf_groups,
  input  logic                   pack_mode,
  input  mrdma_ig_pkg::dim_t     height,
  output logic                   dma_rd_req_vld,
  output logic                   ig2cq_pvld,
  output logic                   cmd_accept,
  output logic                   line_end,
  output logic                   surf_end,
  output logic                   cube_end
);
  import mrdma_ig_pkg::*;

  logic    cmd_process;
  cgroup_t count_c;
  dim_t    count_h;

  // ==================================================
  // command state
  // ==================================================
  // active from the cycle after load until cube end accepted
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_process <= 1'b0;
    end else if (op_load) begin
      cmd_process <= 1'b1;
    end else if (cmd_accept && cube_end) begin
      cmd_process <= 1'b0;
    end
  end

  // each side only sees valid when the other side can take it
  assign dma_rd_req_vld = cmd_process & ig2cq_prdy;
  assign ig2cq_pvld     = cmd_process & dma_rd_req_rdy;
  assign cmd_accept     = dma_rd_req_vld & dma_rd_req_rdy;

  // ==================================================
  // walk flags
  // ==================================================
  // one request per line, so every active step closes a line
  assign line_end = cmd_process;
  // pack mode collapses the whole cube into one step
  assign surf_end = line_end & (pack_mode | (count_h == height));
  assign cube_end = surf_end & (pack_mode | (count_c == surf_groups));

  // channel groups, outer loop
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (op_load) begin
      count_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // lines within a channel group, every accepted step is one line
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (op_load) begin
      count_h <= '0;
    end else if (cmd_accept) begin
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

endmodule

// File: source/mrdma_ig_pkg.sv
// ==================================================
// types for the read request generator: addresses,
// strides, dimensions, sizes and input precision
// ==================================================
`include "mrdma_ig_macros.svh"

package mrdma_ig_pkg;

  // address in 32-byte atoms
  typedef logic [`MRDMA_ADDR_W-`MRDMA_ATOM_SHIFT-1:0] atom_addr_t;

  // line / surface stride, also in atoms
  typedef logic [32-`MRDMA_ATOM_SHIFT-1:0] stride_t;

  // minus-one encoded width, height, channel
  typedef logic [`MRDMA_DIM_W-1:0] dim_t;

  // minus-one channel group count
  typedef logic [`MRDMA_DIM_W-`MRDMA_ATOM_SHIFT:0] cgroup_t;

  typedef logic [`MRDMA_SIZE_W-1:0] req_size_t;

  // input data precision
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,
    PREC_INT16 = 2'd1,
    PREC_FP16  = 2'd2
  } precision_e;

endpackage

// File: source/mrdma_ig_macros.svh
// ==================================================
// field widths and shifts shared by the read request
// generator; included by the package and the RTL
// ==================================================
`ifndef MRDMA_IG_MACROS_SVH
`define MRDMA_IG_MACROS_SVH

// byte address and 32-byte atom
`define MRDMA_ADDR_W      64
`define MRDMA_ATOM_SHIFT  5

// width, height and channel registers
`define MRDMA_DIM_W       13

// request size carried on the dma payload
`define MRDMA_SIZE_W      15

// payloads: dma is {size, addr}, context is {cube_end, size[12:0]}
`define MRDMA_DMA_PD_W    79
`define MRDMA_CQ_PD_W     14

// perf counter
`define MRDMA_STALL_W     32

`endif
